// File: Makefile
# Verilator build and run for the SD data line testbench

SRCS := $(filter-out +%,$(shell cat compile.f)) $(wildcard src/*.svh)

obj_dir/Vsd_dat_tb: compile.f $(SRCS)
	verilator --binary --timing --assert --top-module sd_dat_tb -f compile.f -o Vsd_dat_tb

run: obj_dir/Vsd_dat_tb
	./obj_dir/Vsd_dat_tb

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: compile.f
+incdir+src
src/sd_dat_pkg.sv
src/sd_buf_fifo.sv
src/sd_dat_serializer.sv
src/sd_dat_deserializer.sv
src/sd_dat_ctrl.sv
src/sd_dat_top.sv
test/sd_dat_checks.sv
test/sd_dat_tb.sv

// File: src/sd_buf_fifo.sv
// Synchronous show-ahead FIFO for the host transmit and receive buffers.
// dout always shows the head word; a write when full or a read when empty is ignored.

`timescale 1ns/1ps
`include "sd_dat_config.svh"

module sd_buf_fifo #(
   parameter int DEPTH = `SD_FIFO_DEPTH
) (
   input  logic                   sd_clk,
   input  logic                   rst_L,
   input  logic                   wr_en,
   input  logic                   rd_en,
   input  sd_dat_pkg::fifo_word_t din,
   output sd_dat_pkg::fifo_word_t dout,
   output logic                   empty,
   output logic                   full
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   sd_dat_pkg::fifo_word_t mem [DEPTH];
   logic [AW-1:0] wr_ptr, rd_ptr;
   logic [CW-1:0] count;
   logic          do_wr, do_rd;

   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;
   assign empty = (count == '0);
   assign full  = (count == CW'(DEPTH));
   assign dout  = mem[rd_ptr];   // Head word, before the pop

   always_ff @(posedge sd_clk) begin
      if (do_wr) mem[wr_ptr] <= din;
   end

   always_ff @(posedge sd_clk) begin
      if (!rst_L) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (do_wr && !do_rd)      count <= count + 1'b1;
         else if (do_rd && !do_wr) count <= count - 1'b1;
      end
   end

endmodule

// File: src/sd_dat_config.svh
// Size parameters for the SD data line block.
// Included by the package and by any module that sizes logic from these values.

`ifndef SD_DAT_CONFIG_SVH
`define SD_DAT_CONFIG_SVH

`define SD_FIFO_WIDTH        32                    // Host buffer word
`define SD_NIBBLES_PER_WORD  (`SD_FIFO_WIDTH / 4)  // 4-bit DAT bus
`define SD_BLOCK_SZ_WIDTH    12                    // Block size in bytes
`define SD_BLOCK_CNT_WIDTH   8
`define SD_FIFO_DEPTH        16                    // Words per buffer

`endif

// File: src/sd_dat_ctrl.sv
// Transfer controller for the SD data lines.
// Sequences block writes (busy wait, start nibble, data) and block reads
// (wait for start nibble, data), counting nibbles per block and blocks left.
// DAT_dout and dat_oe are registered so the bus matches the current state.

`timescale 1ns/1ps
`include "sd_dat_config.svh"

module sd_dat_ctrl (
   input  logic                   sd_clk,
   input  logic                   rst_L,
   input  logic                   write_flag,
   input  logic                   read_flag,
   input  logic                   tx_empty,
   input  logic                   rx_full,
   input  sd_dat_pkg::block_sz_t  block_sz,
   input  sd_dat_pkg::block_cnt_t block_cnt,
   input  sd_dat_pkg::nibble_t    DAT_din,
   input  sd_dat_pkg::nibble_t    ser_nibble,
   input  logic                   des_word_valid,
   output logic                   tx_buf_rd_enb,
   output logic                   ser_load,
   output logic                   ser_shift,
   output logic                   des_shift,
   output logic                   rx_buf_wr_enb,
   output sd_dat_pkg::nibble_t    DAT_dout,
   output logic                   dat_oe,
   output logic                   dat_phys_busy,
   output logic                   tf_finished,
   output logic                   rx_overrun
);

   localparam int NW  = `SD_NIBBLES_PER_WORD;
   localparam int NWB = $clog2(NW);
   localparam int NCW = `SD_BLOCK_SZ_WIDTH + 1;   // Two nibbles per byte

   sd_dat_pkg::dat_state_e state, next_state;
   sd_dat_pkg::block_sz_t  blk_sz_q;
   sd_dat_pkg::block_cnt_t blk_left;
   logic [NCW-1:0]         nib_cnt;                // Nibble index within block
   logic [NCW-1:0]         nib_nxt;
   logic [NCW-1:0]         nib_last;
   logic                   last_nib, last_blk, in_data;
   logic                   wr_go, rd_go;
   logic                   load_req, shift_req;

   assign wr_go    = write_flag && !read_flag && !tx_empty;
   assign rd_go    = read_flag && !write_flag;
   assign nib_nxt  = nib_cnt + 1'b1;
   assign nib_last = {blk_sz_q, 1'b0} - 1'b1;
   assign last_nib = (nib_cnt == nib_last);
   assign last_blk = (blk_left == sd_dat_pkg::block_cnt_t'(1));
   assign in_data  = (state == sd_dat_pkg::WR_DATA) || (state == sd_dat_pkg::RD_DATA);

   //////////////////////////////
   // Next state
   //////////////////////////////

   always_comb begin
      next_state = state;
      case (state)
         sd_dat_pkg::IDLE: begin
            if (wr_go)
               next_state = (block_cnt == '0) ? sd_dat_pkg::DONE : sd_dat_pkg::WR_BUSY_WAIT;
            else if (rd_go)
               next_state = (block_cnt == '0) ? sd_dat_pkg::DONE : sd_dat_pkg::RD_WAIT_START;
         end
         sd_dat_pkg::WR_BUSY_WAIT:
            if (DAT_din[0]) next_state = sd_dat_pkg::WR_START;   // Card released DAT0
         sd_dat_pkg::WR_START: next_state = sd_dat_pkg::WR_DATA;
         sd_dat_pkg::WR_DATA:
            if (last_nib) next_state = last_blk ? sd_dat_pkg::DONE : sd_dat_pkg::WR_BUSY_WAIT;
         sd_dat_pkg::RD_WAIT_START:
            if (DAT_din == '0) next_state = sd_dat_pkg::RD_DATA;
         sd_dat_pkg::RD_DATA:
            if (last_nib) next_state = last_blk ? sd_dat_pkg::DONE : sd_dat_pkg::RD_WAIT_START;
         default: next_state = sd_dat_pkg::IDLE;   // DONE lasts one cycle
      endcase
   end

   // Serializer control. The word for nibble index i+1 must be in place
   // when nibble i is registered onto the bus
   always_comb begin
      load_req  = 1'b0;
      shift_req = 1'b0;
      case (state)
         sd_dat_pkg::WR_BUSY_WAIT: load_req  = DAT_din[0] && !tx_empty;
         sd_dat_pkg::WR_START:     shift_req = 1'b1;
         sd_dat_pkg::WR_DATA: begin
            if (!last_nib) begin
               if (nib_nxt[NWB-1:0] == NWB'(NW - 1) && nib_nxt != nib_last) begin
                  if (tx_empty) shift_req = 1'b1;   // Rotate, repeats last word
                  else          load_req  = 1'b1;
               end else begin
                  shift_req = 1'b1;
               end
            end
         end
         default: ;
      endcase
   end

   assign ser_load      = load_req;
   assign tx_buf_rd_enb = load_req;   // Pop as the head is copied
   assign ser_shift     = shift_req;
   assign des_shift     = (state == sd_dat_pkg::RD_DATA);
   assign rx_buf_wr_enb = des_word_valid && !rx_full;
   assign dat_phys_busy = (state != sd_dat_pkg::IDLE);

   //////////////////////////////
   // Registers
   //////////////////////////////

   always_ff @(posedge sd_clk) begin
      if (!rst_L) begin
         state       <= sd_dat_pkg::IDLE;
         DAT_dout    <= '1;
         dat_oe      <= 1'b0;
         tf_finished <= 1'b0;
         rx_overrun  <= 1'b0;
         nib_cnt     <= '0;
         blk_sz_q    <= '0;
         blk_left    <= '0;
      end else begin
         state       <= next_state;
         tf_finished <= (next_state == sd_dat_pkg::DONE);

         // Bus follows the state it is entering
         case (next_state)
            sd_dat_pkg::WR_START: begin
               DAT_dout <= '0;   // Start nibble
               dat_oe   <= 1'b1;
            end
            sd_dat_pkg::WR_DATA: begin
               DAT_dout <= ser_nibble;
               dat_oe   <= 1'b1;
            end
            default: begin
               DAT_dout <= '1;
               dat_oe   <= 1'b0;
            end
         endcase

         if (state == sd_dat_pkg::IDLE && (wr_go || rd_go)) begin
            blk_sz_q <= block_sz;
            blk_left <= block_cnt;
         end else if (in_data && last_nib) begin
            blk_left <= blk_left - 1'b1;
         end

         nib_cnt <= in_data ? nib_nxt : '0;

         if (state == sd_dat_pkg::IDLE && rd_go) rx_overrun <= 1'b0;
         else if (des_word_valid && rx_full)     rx_overrun <= 1'b1;   // Word dropped
      end
   end

endmodule

// File: src/sd_dat_deserializer.sv
// Receive deserializer for the 4-bit DAT bus.
// Each shift appends a nibble at the low end; word_valid pulses for one cycle
// once eight nibbles have landed, first nibble most significant.

`timescale 1ns/1ps
`include "sd_dat_config.svh"

module sd_dat_deserializer (
   input  logic                   sd_clk,
   input  logic                   rst_L,
   input  logic                   shift,
   input  sd_dat_pkg::nibble_t    nibble,
   output sd_dat_pkg::fifo_word_t word,
   output logic                   word_valid
);

   localparam int NW = `SD_NIBBLES_PER_WORD;
   localparam int CW = $clog2(NW);

   logic [CW-1:0] nib_cnt;

   always_ff @(posedge sd_clk) begin
      if (shift) word <= {word[`SD_FIFO_WIDTH-5:0], nibble};
   end

   always_ff @(posedge sd_clk) begin
      if (!rst_L) begin
         nib_cnt    <= '0;
         word_valid <= 1'b0;
      end else begin
         word_valid <= shift && (nib_cnt == CW'(NW - 1));   // Eighth nibble
         if (shift) nib_cnt <= nib_cnt + 1'b1;               // Wraps on its own
      end
   end

endmodule

// File: src/sd_dat_pkg.sv
// Shared types for the SD data line block.
// Modules refer to these with scoped names.

`include "sd_dat_config.svh"

package sd_dat_pkg;

   typedef logic [`SD_FIFO_WIDTH-1:0]      fifo_word_t;
   typedef logic [3:0]                     nibble_t;     // One DAT bus value
   typedef logic [`SD_BLOCK_SZ_WIDTH-1:0]  block_sz_t;
   typedef logic [`SD_BLOCK_CNT_WIDTH-1:0] block_cnt_t;

   // Transfer controller states
   typedef enum logic [2:0] {
      IDLE, WR_BUSY_WAIT, WR_START, WR_DATA, RD_WAIT_START, RD_DATA, DONE
   } dat_state_e;

endpackage

// File: src/sd_dat_serializer.sv
// Transmit word serializer for the 4-bit DAT bus.
// load takes a new word; each shift rotates the next lower nibble to the top,
// so eight shifts bring the word back and an empty buffer repeats it.

`timescale 1ns/1ps
`include "sd_dat_config.svh"

module sd_dat_serializer (
   input  logic                   sd_clk,
   input  logic                   rst_L,
   input  logic                   load,
   input  logic                   shift,
   input  sd_dat_pkg::fifo_word_t word,
   output sd_dat_pkg::nibble_t    nibble
);

   localparam int W = `SD_FIFO_WIDTH;

   sd_dat_pkg::fifo_word_t sh_reg;

   //////////////////////////////
   // Shift register
   //////////////////////////////

   always_ff @(posedge sd_clk) begin
      if (!rst_L) begin
         sh_reg <= '0;
      end else if (load) begin
         sh_reg <= word;
      end else if (shift) begin
         // Top nibble wraps to the bottom
         sh_reg <= {sh_reg[W-5:0], sh_reg[W-1 -: 4]};
      end
   end

   assign nibble = sh_reg[W-1 -: 4];   // MS nibble goes out first

endmodule

// File: src/sd_dat_top.sv
// Top level of the SD data line block.
// Connects the host transmit and receive buffers, the serializer,
// the deserializer and the transfer controller.

`timescale 1ns/1ps
`include "sd_dat_config.svh"

module sd_dat_top (
   input  logic                   sd_clk,
   input  logic                   rst_L,
   input  logic                   tx_wr_en,
   input  sd_dat_pkg::fifo_word_t tx_data,
   input  logic                   rx_rd_en,
   input  logic                   write_flag,
   input  logic                   read_flag,
   input  sd_dat_pkg::block_sz_t  block_sz,
   input  sd_dat_pkg::block_cnt_t block_cnt,
   input  sd_dat_pkg::nibble_t    DAT_din,
   output logic                   tx_full,
   output sd_dat_pkg::fifo_word_t rx_data,
   output logic                   rx_empty,
   output sd_dat_pkg::nibble_t    DAT_dout,
   output logic                   dat_oe,
   output logic                   dat_phys_busy,
   output logic                   tf_finished,
   output logic                   rx_overrun
);

   sd_dat_pkg::fifo_word_t tx_head, des_word;
   sd_dat_pkg::nibble_t    ser_nibble;
   logic tx_empty, rx_full;
   logic tx_buf_rd_enb, rx_buf_wr_enb;
   logic ser_load, ser_shift, des_shift, des_word_valid;

   // Host to card
   sd_buf_fifo #(.DEPTH(`SD_FIFO_DEPTH)) tx_buf (
      .sd_clk, .rst_L, .wr_en(tx_wr_en), .rd_en(tx_buf_rd_enb), .din(tx_data),
      .dout(tx_head), .empty(tx_empty), .full(tx_full)
   );

   // Card to host
   sd_buf_fifo #(.DEPTH(`SD_FIFO_DEPTH)) rx_buf (
      .sd_clk, .rst_L, .wr_en(rx_buf_wr_enb), .rd_en(rx_rd_en), .din(des_word),
      .dout(rx_data), .empty(rx_empty), .full(rx_full)
   );

   sd_dat_serializer ser (
      .sd_clk, .rst_L, .load(ser_load), .shift(ser_shift), .word(tx_head),
      .nibble(ser_nibble)
   );

   sd_dat_deserializer des (
      .sd_clk, .rst_L, .shift(des_shift), .nibble(DAT_din),
      .word(des_word), .word_valid(des_word_valid)
   );

   sd_dat_ctrl ctrl (
      .sd_clk, .rst_L, .write_flag, .read_flag, .tx_empty, .rx_full,
      .block_sz, .block_cnt, .DAT_din, .ser_nibble, .des_word_valid,
      .tx_buf_rd_enb, .ser_load, .ser_shift, .des_shift, .rx_buf_wr_enb,
      .DAT_dout, .dat_oe, .dat_phys_busy, .tf_finished, .rx_overrun
   );

endmodule

// File: test/sd_dat_checks.sv
// Checker for the SD data line testbench.
// Follows host pushes into the transmit buffer and checks every nibble on DAT,
// the start nibble framing, block length, card busy and the transfer outputs.

`timescale 1ns/1ps
`include "sd_dat_config.svh"

module sd_dat_checks (
   input  logic                   sd_clk,
   input  logic                   rst_L,
   input  logic                   tx_wr_en,
   input  logic                   tx_full,
   input  sd_dat_pkg::fifo_word_t tx_data,
   input  sd_dat_pkg::block_sz_t  block_sz,
   input  sd_dat_pkg::nibble_t    DAT_din,
   input  sd_dat_pkg::nibble_t    DAT_dout,
   input  logic                   dat_oe,
   input  logic                   dat_phys_busy,
   input  logic                   tf_finished,
   output logic                   failed,
   output int                     finish_count,
   output int                     tx_left
);

   localparam int TIMEOUT_CYCLES = 4000;   // About 600 cycles of tests plus margin

   sd_dat_pkg::nibble_t tx_nibbles[$];     // Expected write nibbles, in bus order
   sd_dat_pkg::nibble_t exp_nib;
   logic oe_prev, din0_prev, busy_prev, tf_prev;
   int   burst_len, cycles, i;

   task automatic report_fail(string msg);
      if (!failed) $display("[FAIL] %0t ns: %s", $time, msg);
      failed = 1'b1;
   endtask

   //////////////////////////////
   // Sampled on the falling edge
   //////////////////////////////

   always @(negedge sd_clk) begin
      cycles++;
      if (cycles == TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         failed = 1'b1;
      end
      if (!rst_L) begin
         failed       = 1'b0;
         finish_count = 0;
         tx_nibbles.delete();
         oe_prev      = 1'b0;
         din0_prev    = 1'b1;
         busy_prev    = 1'b0;
         tf_prev      = 1'b0;
         burst_len    = 0;
      end else begin
         // Accepted host word, MS nibble first
         if (tx_wr_en && !tx_full) begin
            for (i = `SD_NIBBLES_PER_WORD - 1; i >= 0; i--)
               tx_nibbles.push_back(tx_data[4*i +: 4]);
         end

         if (dat_oe) begin
            assert (dat_phys_busy) else report_fail("dat_oe high outside a transfer");
            if (!oe_prev) begin
               assert (DAT_dout == 4'h0)
                  else report_fail($sformatf("start nibble is %h, not 0", DAT_dout));
               assert (din0_prev) else report_fail("start nibble sent while card held DAT0 low");
               burst_len = 1;
            end else begin
               burst_len++;
               if (tx_nibbles.size() == 0) begin
                  report_fail("data nibble driven with no host word left");
               end else begin
                  exp_nib = tx_nibbles.pop_front();
                  assert (DAT_dout == exp_nib)
                     else report_fail($sformatf("DAT_dout %h, expected %h", DAT_dout, exp_nib));
               end
            end
         end else begin
            assert (DAT_dout == 4'hF) else report_fail("DAT_dout not all ones while released");
            if (oe_prev) begin
               assert (burst_len == 2 * int'(block_sz) + 1)
                  else report_fail($sformatf("block lasted %0d bus cycles", burst_len));
            end
         end

         if (tf_finished) begin
            finish_count++;
            assert (!tf_prev) else report_fail("tf_finished high for more than one cycle");
            assert (dat_phys_busy) else report_fail("tf_finished outside a transfer");
         end
         if (busy_prev && !dat_phys_busy) begin
            assert (tf_prev) else report_fail("dat_phys_busy fell without tf_finished");
         end

         oe_prev   = dat_oe;
         din0_prev = DAT_din[0];
         busy_prev = dat_phys_busy;
         tf_prev   = tf_finished;
      end
      tx_left = tx_nibbles.size();
   end

endmodule

// File: test/sd_dat_tb.sv
// Testbench for the SD data line block.
// Runs single and multi block writes against a card model with busy,
// block reads, flag rejection and receive overrun, then reports the result.

`timescale 1ns/1ps
`include "sd_dat_config.svh"

module sd_dat_tb;

   localparam int DEPTH = `SD_FIFO_DEPTH;

   logic sd_clk, rst_L, tx_wr_en, rx_rd_en, write_flag, read_flag;
   sd_dat_pkg::fifo_word_t tx_data, rx_data;
   sd_dat_pkg::block_sz_t  block_sz;
   sd_dat_pkg::block_cnt_t block_cnt;
   sd_dat_pkg::nibble_t    DAT_din, DAT_dout;
   logic tx_full, rx_empty, dat_oe, dat_phys_busy, tf_finished, rx_overrun;
   logic checker_failed;
   int   finish_count, tx_left;
   int   transfers;                          // Accepted transfers so far
   sd_dat_pkg::fifo_word_t rx_expected[$];

   sd_dat_top sd_dat_top_inst (.*);

   sd_dat_checks checks_inst (
      .sd_clk, .rst_L, .tx_wr_en, .tx_full, .tx_data, .block_sz, .DAT_din, .DAT_dout,
      .dat_oe, .dat_phys_busy, .tf_finished, .failed(checker_failed),
      .finish_count, .tx_left
   );

   initial sd_clk = 1'b0;
   always #20 sd_clk = ~sd_clk;

   always @(posedge checker_failed) begin
      $display(">>> FAIL");
      $fatal(1, "Checker reported an error");
   end

   task automatic error_out(string msg);
      $display("[FAIL] %0t ns: %s", $time, msg);
      $display(">>> FAIL");
      $fatal(1, "Stopped at first error");
   endtask

   // Starts from an empty transmit buffer
   task automatic push_tx_words(int n);
      repeat (n) begin
         @(posedge sd_clk);
         tx_wr_en <= 1'b1;
         tx_data  <= $urandom;
      end
      @(posedge sd_clk) tx_wr_en <= 1'b0;
      @(negedge sd_clk);
      assert (tx_full == (n >= DEPTH)) else error_out("tx_full does not match the words pushed");
   endtask

   // One-cycle flag strobe, returns on the falling edge after it
   task automatic pulse_flag(bit wr, bit rd, int bytes, int blocks);
      @(posedge sd_clk);
      block_sz   <= sd_dat_pkg::block_sz_t'(bytes);
      block_cnt  <= sd_dat_pkg::block_cnt_t'(blocks);
      write_flag <= wr;
      read_flag  <= rd;
      @(posedge sd_clk);
      write_flag <= 1'b0;
      read_flag  <= 1'b0;
      @(negedge sd_clk);
   endtask

   task automatic wait_finish();
      while (!tf_finished) @(negedge sd_clk);
      transfers++;
      @(negedge sd_clk);
      assert (finish_count == transfers)
         else error_out("tf_finished count does not match transfers");
      assert (!dat_phys_busy) else error_out("dat_phys_busy still high after tf_finished");
   endtask

   task automatic write_transfer(int wpb, int blocks, bit busy);
      int oe_cycles;
      int words;
      words = wpb * blocks;
      push_tx_words((words >= DEPTH) ? words + 1 : words);   // Extra push is dropped
      if (!busy) begin
         pulse_flag(1'b1, 1'b1, wpb * 4, blocks);   // Both flags together start nothing
         assert (!dat_phys_busy) else error_out("transfer started with both flags high");
      end
      if (busy) @(posedge sd_clk) DAT_din <= 4'hE;   // Card busy on DAT0
      pulse_flag(1'b1, 1'b0, wpb * 4, blocks);
      assert (dat_phys_busy) else error_out("write_flag not accepted");
      if (busy) begin
         repeat (1 + $urandom % 6) @(posedge sd_clk);
         DAT_din   <= 4'hF;
         read_flag <= 1'b1;                          // Ignored, transfer running
         @(posedge sd_clk) read_flag <= 1'b0;
      end
      for (int b = 0; b < blocks; b++) begin
         oe_cycles = 0;
         while (oe_cycles < wpb * 8 + 1) begin
            @(negedge sd_clk);
            if (dat_oe) oe_cycles++;
         end
         if (busy && b < blocks - 1) begin
            @(posedge sd_clk) DAT_din <= 4'hE;
            repeat (1 + $urandom % 6) @(posedge sd_clk);
            DAT_din <= 4'hF;
         end
      end
      wait_finish();
   endtask

   task automatic read_transfer(int wpb, int blocks);
      sd_dat_pkg::fifo_word_t word;
      sd_dat_pkg::nibble_t    nib;
      pulse_flag(1'b0, 1'b1, wpb * 4, blocks);
      assert (dat_phys_busy) else error_out("read_flag not accepted");
      assert (!rx_overrun) else error_out("rx_overrun not cleared by read_flag");
      for (int b = 0; b < blocks; b++) begin
         @(posedge sd_clk);
         DAT_din <= 4'h0;                            // Start nibble
         if (b == 1) write_flag <= 1'b1;             // Flag while busy
         for (int w = 0; w < wpb; w++) begin
            word = '0;
            repeat (`SD_NIBBLES_PER_WORD) begin
               nib = 4'($urandom);
               @(posedge sd_clk);
               DAT_din    <= nib;
               write_flag <= 1'b0;
               word = {word[`SD_FIFO_WIDTH-5:0], nib};
            end
            rx_expected.push_back(word);
         end
         @(posedge sd_clk) DAT_din <= 4'hF;
      end
      wait_finish();
   endtask

   task automatic pop_and_check(int n);
      sd_dat_pkg::fifo_word_t exp;
      repeat (n) begin
         @(negedge sd_clk);
         assert (!rx_empty) else error_out("receive buffer empty before all words were read");
         exp = rx_expected.pop_front();
         assert (rx_data == exp)
            else error_out($sformatf("rx_data %h, expected %h", rx_data, exp));
         @(posedge sd_clk) rx_rd_en <= 1'b1;
         @(posedge sd_clk) rx_rd_en <= 1'b0;
      end
   endtask

   initial begin
      void'($urandom(66166));
      rst_L      = 1'b0;
      tx_wr_en   = 1'b0;
      tx_data    = '0;
      rx_rd_en   = 1'b0;
      write_flag = 1'b0;
      read_flag  = 1'b0;
      block_sz   = '0;
      block_cnt  = '0;
      DAT_din    = 4'hF;                             // Card idle, not busy
      transfers  = 0;
      repeat (4) @(posedge sd_clk);
      rst_L <= 1'b1;

      @(negedge sd_clk);
      assert (!dat_oe && !dat_phys_busy && !tf_finished && !rx_overrun &&
              DAT_dout == 4'hF && rx_empty)
         else error_out("outputs not at reset values");

      write_transfer(4, 1, 1'b0);
      write_transfer(4, 3, 1'b1);
      write_transfer(DEPTH, 1, 1'b0);                // Fills the transmit buffer

      read_transfer(4, 2);
      assert (!rx_overrun) else error_out("rx_overrun set on a read that fits the buffer");
      pop_and_check(8);

      // Overrun, more words than the buffer holds
      read_transfer(DEPTH + 4, 1);
      assert (rx_overrun) else error_out("rx_overrun not set after receive buffer overflow");
      pop_and_check(DEPTH);
      rx_expected.delete();                          // Dropped words
      @(negedge sd_clk);
      assert (rx_empty) else error_out("receive buffer holds more than its depth");
      read_transfer(1, 1);
      pop_and_check(1);

      @(negedge sd_clk);
      assert (tx_left == 0) else error_out("host words left that were never sent");
      assert (finish_count == transfers) else error_out("extra tf_finished pulse");
      if (checker_failed) begin
         $display(">>> FAIL");
         $fatal(1, "Checker reported an error");
      end else begin
         $display(">>> PASS");
         $finish;
      end
   end

endmodule
